//--- Makefile
SRCS := $(shell grep -v '^+' src.f) hw/upscale_defs.svh

obj_dir/Vupscale_tb: src.f $(SRCS)
	verilator --binary --assert --top-module upscale_tb -f src.f

run: obj_dir/Vupscale_tb
	obj_dir/Vupscale_tb > sim.log 2>&1; status=$$?; cat sim.log; exit $$status
	! grep -q "Test FAILED" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: run clean

//--- hw/interp_unit.sv
`timescale 1ns/1ps
`include "upscale_defs.svh"

module interp_unit
    import upscale_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        pos_valid,
    input  write_mode_t mode_in,
    input  out_addr_t   addr_in,
    input  pixel_t      win_a,
    input  pixel_t      win_b,
    input  pixel_t      win_c,
    input  pixel_t      win_d,
    output logic        en_write_out,
    output write_mode_t write_mode,
    output out_addr_t   addr_output,
    output pixel_t      data_in1,
    output pixel_t      data_in2,
    output pixel_t      data_in3,
    output pixel_t      data_in4,
    output pixel_t      data_in5,
    output pixel_t      data_in6,
    output pixel_t      data_in7,
    output pixel_t      data_in8,
    output pixel_t      data_in9
);

    localparam int SUM_W = `PIX_W + 4;
    localparam logic [SUM_W-1:0] K3 = 3;
    localparam logic [SUM_W-1:0] K9 = 9;

    logic [SUM_W-1:0] ea, eb, ec, ed;
    logic [SUM_W-1:0] hx, hy, vx, vy;
    logic             top_row, left_col;
    pixel_t           corner;

    assign ea = SUM_W'(win_a);
    assign eb = SUM_W'(win_b);
    assign ec = SUM_W'(win_c);
    assign ed = SUM_W'(win_d);

    assign top_row  = (mode_in <= `WM_TR);
    assign left_col = (mode_in == `WM_TL) || (mode_in == `WM_L) || (mode_in == `WM_BL);

    assign hx = top_row ? ea : ec;
    assign hy = top_row ? eb : ed;
    assign vx = left_col ? ea : eb;
    assign vy = left_col ? ec : ed;

    always_comb begin
        case (mode_in)
            `WM_TL:  corner = win_a;
            `WM_TR:  corner = win_b;
            `WM_BL:  corner = win_c;
            default: corner = win_d;  // only used by WM_BR
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            en_write_out <= 1'b0;
            write_mode   <= '0;
            addr_output  <= '0;
        end else begin
            en_write_out <= pos_valid;
            write_mode   <= mode_in;
            addr_output  <= addr_in;
        end
    end

    always_ff @(posedge clk) begin
        data_in1 <= pixel_t'((K9 * ea + K3 * eb + K3 * ec + ed) >> 4);
        data_in2 <= pixel_t'((K3 * ea + K9 * eb + ec + K3 * ed) >> 4);
        data_in3 <= pixel_t'((K3 * ea + eb + K9 * ec + K3 * ed) >> 4);
        data_in4 <= pixel_t'((ea + K3 * eb + K3 * ec + K9 * ed) >> 4);
        data_in5 <= pixel_t'((K3 * hx + hy) >> 2);
        data_in6 <= pixel_t'((hx + K3 * hy) >> 2);
        data_in7 <= pixel_t'((K3 * vx + vy) >> 2);
        data_in8 <= pixel_t'((vx + K3 * vy) >> 2);
        data_in9 <= corner;
    end

endmodule

//--- hw/reg_output.sv
`timescale 1ns/1ps
`include "upscale_defs.svh"

module reg_output
    import upscale_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        en_write_out,
    input  write_mode_t write_mode,
    input  out_addr_t   addr_output,
    input  pixel_t      data_in1,
    input  pixel_t      data_in2,
    input  pixel_t      data_in3,
    input  pixel_t      data_in4,
    input  pixel_t      data_in5,
    input  pixel_t      data_in6,
    input  pixel_t      data_in7,
    input  pixel_t      data_in8,
    input  pixel_t      data_in9,
    output logic [`OUT_DIM*`OUT_DIM*`PIX_W-1:0] dout
);

    localparam int        N_ENT = `OUT_DIM * `OUT_DIM;
    localparam out_addr_t ROW   = out_addr_t'(`OUT_DIM);

    pixel_t    mem [0:N_ENT-1];

    logic      mode_ok;
    logic      top, bot, left, right, corner_en;
    out_addr_t corner_addr;

    out_addr_t a_p1, a_r, a_r1;  // interior
    out_addr_t a_up, a_up1, a_dn, a_dn1;  // row 0 / row 7
    out_addr_t a_l, a_l8, a_rt, a_rt8;  // column 0 / column 7

    always_comb begin
        mode_ok     = 1'b1;
        top         = 1'b0;
        bot         = 1'b0;
        left        = 1'b0;
        right       = 1'b0;
        corner_en   = 1'b0;
        corner_addr = '0;
        case (write_mode)
            `WM_TL: begin
                top       = 1'b1;
                left      = 1'b1;
                corner_en = 1'b1;
            end
            `WM_T: top = 1'b1;
            `WM_TR: begin
                top         = 1'b1;
                right       = 1'b1;
                corner_en   = 1'b1;
                corner_addr = ROW - 6'd1;
            end
            `WM_L: left = 1'b1;
            `WM_C: ;  // interior only
            `WM_R: right = 1'b1;
            `WM_BL: begin
                bot         = 1'b1;
                left        = 1'b1;
                corner_en   = 1'b1;
                corner_addr = out_addr_t'(N_ENT - `OUT_DIM);
            end
            `WM_B: bot = 1'b1;
            `WM_BR: begin
                bot         = 1'b1;
                right       = 1'b1;
                corner_en   = 1'b1;
                corner_addr = out_addr_t'(N_ENT - 1);
            end
            default: mode_ok = 1'b0;
        endcase
    end

    assign a_p1  = addr_output + 6'd1;
    assign a_r   = addr_output + ROW;
    assign a_r1  = addr_output + ROW + 6'd1;
    assign a_up  = addr_output - ROW;
    assign a_up1 = addr_output - ROW + 6'd1;
    assign a_dn  = addr_output + ROW + ROW;
    assign a_dn1 = addr_output + ROW + ROW + 6'd1;
    assign a_l   = addr_output - 6'd1;
    assign a_l8  = addr_output + ROW - 6'd1;
    assign a_rt  = addr_output + 6'd2;
    assign a_rt8 = addr_output + ROW + 6'd2;

    always_ff @(posedge clk) begin
        if (!rst) begin
            for (int i = 0; i < N_ENT; i++) begin
                mem[i] <= '0;
            end
        end else if (en_write_out && mode_ok) begin
            mem[addr_output] <= data_in1;
            mem[a_p1]        <= data_in2;
            mem[a_r]         <= data_in3;
            mem[a_r1]        <= data_in4;
            if (top) begin
                mem[a_up]  <= data_in5;
                mem[a_up1] <= data_in6;
            end
            if (bot) begin
                mem[a_dn]  <= data_in5;
                mem[a_dn1] <= data_in6;
            end
            if (left) begin
                mem[a_l]  <= data_in7;
                mem[a_l8] <= data_in8;
            end
            if (right) begin
                mem[a_rt]  <= data_in7;
                mem[a_rt8] <= data_in8;
            end
            if (corner_en) begin
                mem[corner_addr] <= data_in9;
            end
        end
    end

    // entry 63 ends up in the top bits
    always_comb begin
        for (int i = 0; i < N_ENT; i++) begin
            dout[i*`PIX_W +: `PIX_W] = mem[i];
        end
    end

    a_mode_range: assert property (@(posedge clk) disable iff (!rst)
        en_write_out |-> write_mode <= `WM_BR);

endmodule

//--- hw/scan_ctrl.sv
`timescale 1ns/1ps
`include "upscale_defs.svh"

module scan_ctrl
    import upscale_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        start,
    output logic        busy,
    output logic        done,
    output logic        pos_valid,
    output win_idx_t    win_row,
    output win_idx_t    win_col,
    output write_mode_t write_mode,
    output out_addr_t   addr_output
);

    localparam win_idx_t LAST_WIN = win_idx_t'(`IN_DIM - 2);

    scan_state_t state;
    win_idx_t    row;
    win_idx_t    col;
    logic        drain_last;  // second drain cycle

    always_ff @(posedge clk) begin
        if (!rst) begin
            state      <= IDLE;
            row        <= '0;
            col        <= '0;
            drain_last <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    if (start) begin
                        state <= SCAN;
                        row   <= '0;
                        col   <= '0;
                    end
                end
                SCAN: begin
                    if (col == LAST_WIN) begin
                        col <= '0;
                        if (row == LAST_WIN) begin
                            row        <= '0;
                            drain_last <= 1'b0;
                            state      <= DRAIN;
                        end else begin
                            row <= row + 2'd1;
                        end
                    end else begin
                        col <= col + 2'd1;
                    end
                end
                DRAIN: begin
                    // one cycle for the interp stage, one for the last write
                    if (drain_last) begin
                        drain_last <= 1'b0;
                        state      <= IDLE;
                    end else begin
                        drain_last <= 1'b1;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    assign busy       = (state != IDLE);
    assign pos_valid  = (state == SCAN);
    assign done       = (state == DRAIN) && drain_last;
    assign win_row    = row;
    assign win_col    = col;
    assign write_mode = write_mode_t'({row, 1'b0}) + write_mode_t'(row) + write_mode_t'(col);
    assign addr_output = {row, 1'b1, col, 1'b1};  // 8*(2r+1) + (2c+1)

    a_done_pulse: assert property (@(posedge clk) disable iff (!rst) done |=> !done);

    // a position in flight keeps busy up
    a_valid_busy: assert property (@(posedge clk) disable iff (!rst) pos_valid |=> busy);

endmodule

//--- hw/upscale_defs.svh
`ifndef UPSCALE_DEFS_SVH
`define UPSCALE_DEFS_SVH

`define PIX_W   12
`define IN_DIM  4
`define OUT_DIM 8

// window position code is 3 * window row + window column
`define WM_TL 4'd0
`define WM_T  4'd1
`define WM_TR 4'd2
`define WM_L  4'd3
`define WM_C  4'd4
`define WM_R  4'd5
`define WM_BL 4'd6
`define WM_B  4'd7
`define WM_BR 4'd8

`endif

//--- hw/upscale_pkg.sv
`include "upscale_defs.svh"

package upscale_pkg;

    typedef logic [`PIX_W-1:0] pixel_t;

    // index into the 8x8 output bank
    typedef logic [$clog2(`OUT_DIM*`OUT_DIM)-1:0] out_addr_t;

    typedef logic [1:0] win_idx_t;

    typedef logic [3:0] write_mode_t;

    typedef enum logic [1:0] {
        IDLE,
        SCAN,
        DRAIN
    } scan_state_t;

endpackage

//--- hw/upscale_top.sv
`timescale 1ns/1ps
`include "upscale_defs.svh"

module upscale_top
    import upscale_pkg::*;
(
    input  logic   clk,
    input  logic   rst,
    input  logic   pix_valid,
    input  pixel_t pix_data,
    input  logic   start,
    output logic   busy,
    output logic   done,
    output logic [`OUT_DIM*`OUT_DIM*`PIX_W-1:0] dout
);

    win_idx_t    win_row, win_col;
    pixel_t      win_a, win_b, win_c, win_d;
    logic        pos_valid;
    write_mode_t scan_mode;
    out_addr_t   scan_addr;

    logic        en_write_out;
    write_mode_t write_mode;
    out_addr_t   addr_output;
    pixel_t      data_in1, data_in2, data_in3, data_in4, data_in5;
    pixel_t      data_in6, data_in7, data_in8, data_in9;

    window_fetch fetch_i (
        .clk(clk), .rst(rst), .pix_valid(pix_valid), .pix_data(pix_data), .busy(busy),
        .win_row(win_row), .win_col(win_col),
        .win_a(win_a), .win_b(win_b), .win_c(win_c), .win_d(win_d)
    );

    scan_ctrl scan_i (
        .clk(clk), .rst(rst), .start(start), .busy(busy), .done(done),
        .pos_valid(pos_valid), .win_row(win_row), .win_col(win_col),
        .write_mode(scan_mode), .addr_output(scan_addr)
    );

    interp_unit interp_i (
        .clk(clk), .rst(rst), .pos_valid(pos_valid), .mode_in(scan_mode), .addr_in(scan_addr),
        .win_a(win_a), .win_b(win_b), .win_c(win_c), .win_d(win_d),
        .en_write_out(en_write_out), .write_mode(write_mode), .addr_output(addr_output),
        .data_in1(data_in1), .data_in2(data_in2), .data_in3(data_in3),
        .data_in4(data_in4), .data_in5(data_in5), .data_in6(data_in6),
        .data_in7(data_in7), .data_in8(data_in8), .data_in9(data_in9)
    );

    reg_output out_i (
        .clk(clk), .rst(rst), .en_write_out(en_write_out),
        .write_mode(write_mode), .addr_output(addr_output),
        .data_in1(data_in1), .data_in2(data_in2), .data_in3(data_in3),
        .data_in4(data_in4), .data_in5(data_in5), .data_in6(data_in6),
        .data_in7(data_in7), .data_in8(data_in8), .data_in9(data_in9),
        .dout(dout)
    );

endmodule

//--- hw/window_fetch.sv
`timescale 1ns/1ps
`include "upscale_defs.svh"

module window_fetch
    import upscale_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  logic     pix_valid,
    input  pixel_t   pix_data,
    input  logic     busy,
    input  win_idx_t win_row,
    input  win_idx_t win_col,
    output pixel_t   win_a,
    output pixel_t   win_b,
    output pixel_t   win_c,
    output pixel_t   win_d
);

    localparam int TILE_N = `IN_DIM * `IN_DIM;

    pixel_t     tile [0:TILE_N-1];
    logic [3:0] wr_ptr;  // raster position that wraps after 16
    logic [3:0] base;

    always_ff @(posedge clk) begin
        if (!rst) begin
            wr_ptr <= '0;
        end else if (pix_valid && !busy) begin
            wr_ptr <= wr_ptr + 4'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (pix_valid && !busy) begin
            tile[wr_ptr] <= pix_data;
        end
    end

    // row * 4 + col
    assign base = {win_row, win_col};

    assign win_a = tile[base];
    assign win_b = tile[base + 4'd1];
    assign win_c = tile[base + 4'(`IN_DIM)];
    assign win_d = tile[base + 4'(`IN_DIM + 1)];

endmodule

//--- src.f
+incdir+hw
hw/upscale_pkg.sv
hw/window_fetch.sv
hw/scan_ctrl.sv
hw/interp_unit.sv
hw/reg_output.sv
hw/upscale_top.sv
tests/upscale_tb.sv

//--- tests/upscale_cases.txt
# name, 16 tile pixels in raster order (row 0 first), expected dout as 192 hex digits
# dout digits run from output entry 63 (row 7, col 7) down to entry 0 (row 0, col 0)
flat_5a5 5a5 5a5 5a5 5a5 5a5 5a5 5a5 5a5 5a5 5a5 5a5 5a5 5a5 5a5 5a5 5a5 5a55a55a55a55a55a55a55a55a55a55a55a55a55a55a55a55a55a55a55a55a55a55a55a55a55a55a55a55a55a55a55a55a55a55a55a55a55a55a55a55a55a55a55a55a55a55a55a55a55a55a55a55a55a55a55a55a55a55a55a55a55a55a55a55a55a55a55a5
ramp_xy 010 050 090 0d0 110 150 190 1d0 210 250 290 2d0 310 350 390 3d0 3d03c03a03803603403203103903803603403203002e02d03103002e02c02a02802602502902802602402202001e01d02102001e01c01a01801601501901801601401201000e00d01101000e00c00a00800600500d00c00a0080060040020010
ramp_frac 200 203 206 209 205 208 20b 20e 20a 20d 210 213 20f 212 215 218 21821721521421221120f20f21621621421321121020e20d21421321221020f20d20c20b21121120f20e20c20b20920820f20e20d20b20a20820720620c20c20a20920720620420320a209208206205203202201209208206205203202200200
flat_fff fff fff fff fff fff fff fff fff fff fff fff fff fff fff fff fff ffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffff
flat_000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000

//--- tests/upscale_tb.sv
`timescale 1ns/1ps
`include "upscale_defs.svh"

module upscale_tb
    import upscale_pkg::*;
();

    localparam int FRAME_W = `OUT_DIM * `OUT_DIM * `PIX_W;
    localparam int TILE_N  = `IN_DIM * `IN_DIM;
    localparam int LATENCY = 11;  // start edge to done pulse
    localparam int MAX_WAIT = 40;

    logic               clk;
    logic               rst;
    logic               pix_valid;
    pixel_t             pix_data;
    logic               start;
    logic               busy;
    logic               done;
    logic [FRAME_W-1:0] dout;

    string              case_name [$];
    pixel_t             case_pix [$];  // 16 per case in raster order
    logic [FRAME_W-1:0] case_exp [$];
    int                 n_cases;
    bit                 loaded;
    int                 n_pass;
    int                 n_fail;

    upscale_top dut_i (
        .clk(clk), .rst(rst), .pix_valid(pix_valid), .pix_data(pix_data),
        .start(start), .busy(busy), .done(done), .dout(dout)
    );

    always #10 clk = ~clk;

    task automatic read_cases();
        int                 fd;
        int                 code;
        string              tok;
        string              rest;
        pixel_t             p;
        logic [FRAME_W-1:0] e;
        fd = $fopen("tests/upscale_cases.txt", "r");
        if (fd == 0) begin
            $display("could not open tests/upscale_cases.txt");
            return;
        end
        while (!$feof(fd)) begin
            code = $fscanf(fd, "%s", tok);
            if (code != 1) begin
                break;
            end
            if (tok.substr(0, 0) == "#") begin
                code = $fgets(rest, fd);  // skip comment line
                continue;
            end
            case_name.push_back(tok);
            for (int i = 0; i < TILE_N; i++) begin
                code = $fscanf(fd, "%h", p);
                case_pix.push_back(p);
            end
            code = $fscanf(fd, "%h", e);
            case_exp.push_back(e);
        end
        $fclose(fd);
    endtask

    task automatic tally(string name, bit ok);
        if (ok) begin
            n_pass++;
            $display("%s: pass", name);
        end else begin
            n_fail++;
            $display("%s: fail", name);
        end
    endtask

    task automatic check_reset();
        bit ok;
        ok = 1'b1;
        @(negedge clk);
        if (dout !== '0) begin
            $display("** Error reset: dout expected %h, actual %h", {FRAME_W{1'b0}}, dout);
            ok = 1'b0;
        end
        if (busy !== 1'b0) begin
            $display("** Error reset: busy expected 0, actual %b", busy);
            ok = 1'b0;
        end
        if (done !== 1'b0) begin
            $display("** Error reset: done expected 0, actual %b", done);
            ok = 1'b0;
        end
        tally("reset", ok);
    endtask

    task automatic load_tile(int idx);
        for (int i = 0; i < TILE_N; i++) begin
            @(posedge clk);
            pix_valid <= 1'b1;
            pix_data  <= case_pix[idx*TILE_N + i];
        end
        @(posedge clk);
        pix_valid <= 1'b0;
    endtask

    // disturb adds a second start and stray pixels while the scan runs
    task automatic run_frame(int idx, bit disturb);
        int                 cyc;
        int                 done_at;
        int                 n_done;
        bit                 ok;
        logic [FRAME_W-1:0] got;
        ok      = 1'b1;
        cyc     = 0;
        done_at = 0;
        n_done  = 0;
        got     = '0;
        load_tile(idx);
        @(posedge clk);
        start <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
        while (cyc < MAX_WAIT && (done_at == 0 || cyc < done_at + 4)) begin
            @(negedge clk);
            cyc++;
            if (done) begin
                n_done++;
                if (done_at == 0) begin
                    done_at = cyc;
                    got     = dout;  // frame as seen with done
                end
            end
            if (cyc <= LATENCY && busy !== 1'b1) begin
                $display("** Error %s: busy in cycle %0d expected 1, actual %b",
                         case_name[idx], cyc, busy);
                ok = 1'b0;
            end
            if (cyc > LATENCY && busy !== 1'b0) begin
                $display("** Error %s: busy in cycle %0d expected 0, actual %b",
                         case_name[idx], cyc, busy);
                ok = 1'b0;
            end
            @(posedge clk);
            if (disturb) begin
                start     <= (cyc == 2);
                pix_valid <= (cyc >= 2 && cyc <= 5);  // cycles 3 to 6
                pix_data  <= 12'hc3c;
            end
        end
        if (done_at == 0) begin
            $display("%s: done never came within %0d cycles of start", case_name[idx], MAX_WAIT);
            ok = 1'b0;
        end else begin
            if (done_at != LATENCY) begin
                $display("** Error %s: done cycle expected %0d, actual %0d",
                         case_name[idx], LATENCY, done_at);
                ok = 1'b0;
            end
            if (n_done != 1) begin
                $display("** Error %s: done pulses expected 1, actual %0d", case_name[idx], n_done);
                ok = 1'b0;
            end
            if (got !== case_exp[idx]) begin
                $display("** Error %s: dout expected %h, actual %h",
                         case_name[idx], case_exp[idx], got);
                ok = 1'b0;
            end
        end
        tally(case_name[idx], ok);
    endtask

    initial begin
        wait (loaded);
        #((n_cases * MAX_WAIT + 100) * 20);
        $display("watchdog: simulation ran past its time limit");
        $display("Test FAILED");
        $finish;
    end

    initial begin
        clk       = 1'b0;
        rst       = 1'b0;
        pix_valid = 1'b0;
        pix_data  = '0;
        start     = 1'b0;
        n_pass    = 0;
        n_fail    = 0;
        read_cases();
        n_cases = case_name.size();
        loaded  = 1'b1;
        repeat (2) @(posedge clk);
        rst <= 1'b1;
        check_reset();
        for (int i = 0; i < n_cases; i++) begin
            run_frame(i, i % 2 == 1);
        end
        if (n_cases == 0) begin
            $display("no test cases were read");
            n_fail++;
        end
        $display("tests: %0d, passed: %0d, failed: %0d", n_pass + n_fail, n_pass, n_fail);
        if (n_fail == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule
